//--- Makefile
VERILATOR ?= verilator
TOP       ?= serial_bus_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ** PASS **

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
source/serial_bus_pkg.sv
source/ack_timer.sv
source/master_port.sv
source/bus_controller.sv
source/serial_crossbar.sv
source/slave_port.sv
source/serial_bus_top.sv
verif/serial_bus_tb.sv

//--- source/ack_timer.sv
`timescale 1ns/10ps

module ack_timer import serial_bus_pkg::*; #(
  parameter int ACK_TIMEOUT = DEF_ACK_TIMEOUT
) (
  input  logic clk,
  input  logic rstN,
  input  logic run,
  output logic expired
);

  localparam int CNT_WIDTH = $clog2(ACK_TIMEOUT + 1);

  logic [CNT_WIDTH-1:0] count;

  // saturates at the timeout until run drops
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      count <= '0;
    end else if (!run) begin
      count <= '0;
    end else if (!expired) begin
      count <= count + 1'b1;
    end
  end

  assign expired = (count == CNT_WIDTH'(ACK_TIMEOUT));

endmodule

//--- source/bus_controller.sv
`timescale 1ns/10ps

module bus_controller import serial_bus_pkg::*; #(
  parameter int NO_MASTERS = DEF_NO_MASTERS,
  parameter int NO_SLAVES  = DEF_NO_SLAVES
) (
  input  logic clk,
  input  logic rstN,
  input  logic [NO_MASTERS-1:0][$clog2(NO_SLAVES + 1)-1:0] id,
  input  logic [NO_MASTERS-1:0] done,
  output bus_cmd_t [NO_MASTERS-1:0] cmd,
  output logic [NO_SLAVES-1:0][((NO_MASTERS > 1) ? $clog2(NO_MASTERS) : 1)-1:0] slave_owner,
  output logic [NO_SLAVES-1:0] owner_valid
);

  localparam int S_ID_WIDTH = $clog2(NO_SLAVES + 1);
  localparam int M_ID_WIDTH = (NO_MASTERS > 1) ? $clog2(NO_MASTERS) : 1;

  logic [NO_MASTERS-1:0] granted;     // set on grant, cleared once id drops
  logic [NO_MASTERS-1:0] grant_vec;

  //////////////////////////////////////////////////////////////////////
  // fixed priority scan, master 0 first
  //////////////////////////////////////////////////////////////////////
  always_comb begin : grant_scan
    logic [NO_SLAVES-1:0] claimed;
    int                   sidx;
    claimed   = owner_valid;
    grant_vec = '0;
    for (int m = 0; m < NO_MASTERS; m++) begin
      sidx = int'(id[m]) - 1;
      if ((id[m] != '0) && !granted[m] &&
          (id[m] <= S_ID_WIDTH'(NO_SLAVES)) && !claimed[sidx]) begin
        grant_vec[m]  = 1'b1;
        claimed[sidx] = 1'b1;   // lower priority masters lose this slave
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int m = 0; m < NO_MASTERS; m++) begin
        cmd[m] <= CMD_HOLD;
      end
      granted     <= '0;
      slave_owner <= '0;
      owner_valid <= '0;
    end else begin
      for (int m = 0; m < NO_MASTERS; m++) begin
        cmd[m] <= CMD_HOLD;
      end

      // free whatever the finishing master holds
      for (int s = 0; s < NO_SLAVES; s++) begin
        if (owner_valid[s] && done[slave_owner[s]]) begin
          owner_valid[s]          <= 1'b0;
          cmd[slave_owner[s]]     <= CMD_RELEASE_ACK;
        end
      end

      for (int m = 0; m < NO_MASTERS; m++) begin
        if (grant_vec[m]) begin
          owner_valid[id[m] - 1'b1] <= 1'b1;
          slave_owner[id[m] - 1'b1] <= M_ID_WIDTH'(m);
          cmd[m]                    <= CMD_GRANT;   // single cycle
          granted[m]                <= 1'b1;
        end else if (id[m] == '0) begin
          granted[m] <= 1'b0;
        end
      end
    end
  end

endmodule

//--- source/master_port.sv
`timescale 1ns/10ps

module master_port import serial_bus_pkg::*; #(
  parameter int NO_SLAVES   = DEF_NO_SLAVES,
  parameter int ACK_TIMEOUT = DEF_ACK_TIMEOUT
) (
  input  logic clk,
  input  logic rstN,
  input  logic port_in,
  output logic port_out,
  input  bus_cmd_t cmd,
  output logic [$clog2(NO_SLAVES + 1)-1:0] id,
  output logic done,
  output logic bit_data,
  output logic bit_valid
);

  localparam int S_ID_WIDTH   = $clog2(NO_SLAVES + 1);
  localparam int BUF_WIDTH    = (S_ID_WIDTH > 3) ? S_ID_WIDTH : 3;
  localparam int ID_CNT_WIDTH = $clog2(S_ID_WIDTH + 1);

  mport_state_t state;

  logic [BUF_WIDTH-2:0]    shift_buf;
  logic [BUF_WIDTH-1:0]    buf_next;     // shift_buf including this cycle's bit
  logic [ID_CNT_WIDTH-1:0] id_cnt;
  logic [1:0]              pat_idx;      // response bit on the line
  logic                    half;         // second bit of a symbol pair
  logic                    timer_run;
  logic                    timer_expired;

  assign buf_next  = {shift_buf, port_in};
  assign timer_run = (state == REQUEST);

  ack_timer #(
    .ACK_TIMEOUT(ACK_TIMEOUT)
  ) u_ack_timer (
    .clk    (clk),
    .rstN   (rstN),
    .run    (timer_run),
    .expired(timer_expired)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shift_buf <= '0;
    end else begin
      shift_buf <= buf_next[BUF_WIDTH-2:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // port state machine
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= IDLE;
      port_out  <= 1'b0;
      id        <= '0;
      done      <= 1'b0;
      bit_data  <= 1'b0;
      bit_valid <= 1'b0;
      id_cnt    <= '0;
      pat_idx   <= '0;
      half      <= 1'b0;
    end else begin
      done      <= 1'b0;
      bit_valid <= 1'b0;
      unique case (state)
        IDLE: begin
          if (buf_next[2:0] == START_PATTERN) begin
            id_cnt <= '0;
            state  <= ID_SHIFT;
          end
        end
        ID_SHIFT: begin
          id_cnt <= id_cnt + 1'b1;
          if (id_cnt == ID_CNT_WIDTH'(S_ID_WIDTH - 1)) begin   // last id bit
            id    <= buf_next[S_ID_WIDTH-1:0];
            state <= REQUEST;
          end
        end
        REQUEST: begin
          if (cmd == CMD_GRANT) begin
            port_out <= RSP_ACK[2];
            pat_idx  <= 2'd2;
            state    <= RESPOND_ACK;
          end else if (timer_expired) begin
            port_out <= RSP_NAK[2];
            pat_idx  <= 2'd2;
            id       <= '0;        // withdraw the request
            state    <= RESPOND_NAK;
          end
        end
        RESPOND_ACK: begin
          pat_idx <= pat_idx - 1'b1;
          if (pat_idx == 2'd0) begin
            port_out <= 1'b0;
            half     <= 1'b0;      // symbol pairs start on this cycle's boundary
            state    <= COM;
          end else begin
            port_out <= RSP_ACK[pat_idx - 2'd1];
          end
        end
        RESPOND_NAK: begin
          // a grant that raced the timeout is handed straight back
          done    <= (cmd == CMD_GRANT);
          pat_idx <= pat_idx - 1'b1;
          if (pat_idx == 2'd0) begin
            port_out <= 1'b0;
            state    <= IDLE;
          end else begin
            port_out <= RSP_NAK[pat_idx - 2'd1];
          end
        end
        COM: begin
          half <= ~half;
          if (half) begin
            unique case (buf_next[1:0])
              SYM_ZERO, SYM_ONE: begin
                bit_data  <= port_in;   // second bit carries the value
                bit_valid <= 1'b1;
              end
              SYM_END: begin
                done  <= 1'b1;
                state <= RELEASE;
              end
              SYM_IDLE: bit_valid <= 1'b0;
            endcase
          end
        end
        RELEASE: begin
          if (cmd == CMD_RELEASE_ACK) begin
            id    <= '0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- source/serial_bus_pkg.sv
package serial_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // default sizes, overridden from the top level
  //////////////////////////////////////////////////////////////////////
  localparam int DEF_NO_MASTERS  = 2;
  localparam int DEF_NO_SLAVES   = 3;
  localparam int DEF_DATA_WIDTH  = 8;
  localparam int DEF_ACK_TIMEOUT = 16;   // cycles to wait for a grant

  typedef logic [DEF_DATA_WIDTH-1:0] byte_t;

  // controller to master port, code 2'b11 reserved
  typedef enum logic [1:0] {
    CMD_HOLD        = 2'b00,
    CMD_GRANT       = 2'b01,
    CMD_RELEASE_ACK = 2'b10
  } bus_cmd_t;

  localparam logic [2:0] START_PATTERN = 3'b111;
  localparam logic [2:0] RSP_ACK       = 3'b101;
  localparam logic [2:0] RSP_NAK       = 3'b110;

  // two-bit data symbols, first bit on the line is the msb
  localparam logic [1:0] SYM_IDLE = 2'b00;
  localparam logic [1:0] SYM_END  = 2'b01;
  localparam logic [1:0] SYM_ZERO = 2'b10;
  localparam logic [1:0] SYM_ONE  = 2'b11;

  typedef enum logic [2:0] {
    IDLE,
    ID_SHIFT,
    REQUEST,
    RESPOND_ACK,
    RESPOND_NAK,
    COM,
    RELEASE
  } mport_state_t;

endpackage

//--- source/serial_bus_top.sv
`timescale 1ns/10ps

module serial_bus_top import serial_bus_pkg::*; #(
  parameter int NO_MASTERS  = DEF_NO_MASTERS,
  parameter int NO_SLAVES   = DEF_NO_SLAVES,
  parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
  parameter int ACK_TIMEOUT = DEF_ACK_TIMEOUT
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [NO_MASTERS-1:0] port_in,
  output logic [NO_MASTERS-1:0] port_out,
  output byte_t [NO_SLAVES-1:0] byte_data,
  output logic [NO_SLAVES-1:0]  byte_valid
);

  localparam int S_ID_WIDTH = $clog2(NO_SLAVES + 1);
  localparam int M_ID_WIDTH = (NO_MASTERS > 1) ? $clog2(NO_MASTERS) : 1;

  logic [NO_MASTERS-1:0][S_ID_WIDTH-1:0] port_id;
  bus_cmd_t [NO_MASTERS-1:0]             port_cmd;
  logic [NO_MASTERS-1:0]                 port_done;
  logic [NO_MASTERS-1:0]                 bit_data;
  logic [NO_MASTERS-1:0]                 bit_valid;
  logic [NO_SLAVES-1:0][M_ID_WIDTH-1:0]  slave_owner;
  logic [NO_SLAVES-1:0]                  owner_valid;
  logic [NO_SLAVES-1:0]                  s_bit;
  logic [NO_SLAVES-1:0]                  s_bit_valid;
  logic [NO_SLAVES-1:0]                  frame_end;

  for (genvar m = 0; m < NO_MASTERS; m++) begin : g_master
    master_port #(.NO_SLAVES(NO_SLAVES), .ACK_TIMEOUT(ACK_TIMEOUT)) u_master_port (
      .clk(clk), .rstN(rstN), .port_in(port_in[m]), .port_out(port_out[m]),
      .cmd(port_cmd[m]), .id(port_id[m]), .done(port_done[m]),
      .bit_data(bit_data[m]), .bit_valid(bit_valid[m])
    );
  end

  bus_controller #(.NO_MASTERS(NO_MASTERS), .NO_SLAVES(NO_SLAVES)) u_bus_controller (
    .clk(clk), .rstN(rstN), .id(port_id), .done(port_done), .cmd(port_cmd),
    .slave_owner(slave_owner), .owner_valid(owner_valid)
  );

  serial_crossbar #(.NO_MASTERS(NO_MASTERS), .NO_SLAVES(NO_SLAVES)) u_serial_crossbar (
    .bit_data(bit_data), .bit_valid(bit_valid), .done(port_done),
    .slave_owner(slave_owner), .owner_valid(owner_valid),
    .s_bit(s_bit), .s_bit_valid(s_bit_valid), .frame_end(frame_end)
  );

  for (genvar s = 0; s < NO_SLAVES; s++) begin : g_slave
    slave_port #(.DATA_WIDTH(DATA_WIDTH)) u_slave_port (
      .clk(clk), .rstN(rstN), .s_bit(s_bit[s]), .s_bit_valid(s_bit_valid[s]),
      .frame_end(frame_end[s]), .byte_data(byte_data[s]), .byte_valid(byte_valid[s])
    );
  end

endmodule

//--- source/serial_crossbar.sv
`timescale 1ns/10ps

module serial_crossbar import serial_bus_pkg::*; #(
  parameter int NO_MASTERS = DEF_NO_MASTERS,
  parameter int NO_SLAVES  = DEF_NO_SLAVES
) (
  input  logic [NO_MASTERS-1:0] bit_data,
  input  logic [NO_MASTERS-1:0] bit_valid,
  input  logic [NO_MASTERS-1:0] done,
  input  logic [NO_SLAVES-1:0][((NO_MASTERS > 1) ? $clog2(NO_MASTERS) : 1)-1:0] slave_owner,
  input  logic [NO_SLAVES-1:0] owner_valid,
  output logic [NO_SLAVES-1:0] s_bit,
  output logic [NO_SLAVES-1:0] s_bit_valid,
  output logic [NO_SLAVES-1:0] frame_end
);

  // each slave listens only to its current owner
  always_comb begin
    s_bit       = '0;
    s_bit_valid = '0;
    frame_end   = '0;
    for (int s = 0; s < NO_SLAVES; s++) begin
      if (owner_valid[s]) begin
        s_bit[s]       = bit_data[slave_owner[s]];
        s_bit_valid[s] = bit_valid[slave_owner[s]];
        frame_end[s]   = done[slave_owner[s]];   // owner is about to release
      end
    end
  end

endmodule

//--- source/slave_port.sv
`timescale 1ns/10ps

module slave_port import serial_bus_pkg::*; #(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH
) (
  input  logic  clk,
  input  logic  rstN,
  input  logic  s_bit,
  input  logic  s_bit_valid,
  input  logic  frame_end,
  output byte_t byte_data,
  output logic  byte_valid
);

  localparam int CNT_WIDTH = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

  logic [CNT_WIDTH-1:0] bit_cnt;
  byte_t                shift_reg;

  //////////////////////////////////////////////////////////////////////
  // byte assembly, msb first
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (s_bit_valid) begin
      shift_reg <= {shift_reg[$bits(byte_t)-2:0], s_bit};
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (frame_end) begin
        bit_cnt <= '0;                 // partial byte is dropped
      end else if (s_bit_valid) begin
        if (bit_cnt == CNT_WIDTH'(DATA_WIDTH - 1)) begin
          bit_cnt    <= '0;
          byte_valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // bits arrive at most every other cycle, so the byte holds while valid
  assign byte_data = shift_reg;

endmodule

//--- verif/serial_bus_golden.txt
# gap | master 0: en id delay nbits data rsp latchk | master 1: same | slave 1..3: count bytes
# all hex, data bits sent msb first, rsp 5 = ack 101, 6 = nak 110, bytes listed in arrival order
# single transfer, master 0 to slave 1
1  1 1 0 10 0000a53c 5 1  0 0 0 00 00000000 0 0  2 0000a53c 0 00000000 0 00000000
# single transfer, master 1 to slave 3
0  0 0 0 00 00000000 0 0  1 3 0 08 00000096 5 1  0 00000000 0 00000000 1 00000096
# id 0 from both masters, refused by timeout
0  1 0 0 08 000000ff 6 1  1 0 0 08 000000ff 6 1  0 00000000 0 00000000 0 00000000
# busy slave, master 0 holds slave 2 while master 1 asks for it
1  1 2 0 20 11223344 5 1  1 2 4 08 000000ff 6 1  0 00000000 4 11223344 0 00000000
# priority, both ask slave 3 together, master 1 served after release
0  1 3 0 08 0000007e 5 1  1 3 0 08 00000081 5 0  0 00000000 0 00000000 2 00007e81
# parallel transfers to slaves 1 and 2
1  1 1 0 10 00000ff0 5 1  1 2 0 10 0000c35a 5 1  2 00000ff0 2 0000c35a 0 00000000
# incomplete byte, trailing 4 bits dropped
1  1 2 0 0c 000005a3 5 1  0 0 0 00 00000000 0 0  0 00000000 1 0000005a 0 00000000
# next frame to slave 2 assembles from bit 0 again
0  0 0 0 00 00000000 0 0  1 2 0 08 00000096 5 1  0 00000000 1 00000096 0 00000000

//--- verif/serial_bus_tb.sv
`timescale 1ns/10ps

module serial_bus_tb import serial_bus_pkg::*; ();

  localparam int NO_MASTERS  = 2;
  localparam int NO_SLAVES   = 3;
  localparam int DATA_WIDTH  = 8;
  localparam int ACK_TIMEOUT = 32;   // room for a one-byte frame while another master waits
  localparam int S_ID_WIDTH  = $clog2(NO_SLAVES + 1);
  localparam int MAX_TESTS   = 16;
  localparam int MAX_GAP     = 2;    // idle pairs before a symbol
  localparam int MAX_BYTES   = 32;
  localparam int NO_FIELDS   = 21;
  localparam logic [31:0] SEED = 32'hb5c0_76d4;

  // golden line layout, frame groups of 7 fields start at 1
  localparam int F_GAP  = 0;
  localparam int F_EN   = 0;
  localparam int F_ID   = 1;
  localparam int F_DLY  = 2;
  localparam int F_NB   = 3;
  localparam int F_DATA = 4;
  localparam int F_RSP  = 5;
  localparam int F_LAT  = 6;
  localparam int F_SLV  = 15;   // count and bytes per slave

  logic                  clk;
  logic                  rstN;
  logic [NO_MASTERS-1:0] port_in;
  logic [NO_MASTERS-1:0] port_out;
  byte_t [NO_SLAVES-1:0] byte_data;
  logic [NO_SLAVES-1:0]  byte_valid;

  logic [31:0] gold [MAX_TESTS][NO_FIELDS];
  logic [31:0] rng_state [NO_MASTERS];
  byte_t       got_mem [NO_SLAVES][MAX_BYTES];
  int          got_cnt [NO_SLAVES];
  int          num_tests;
  int          cycle;
  int          cycle_limit;
  int          errors;
  int          checks;
  int          passed;
  int          failed;

  serial_bus_top #(
    .NO_MASTERS (NO_MASTERS),
    .NO_SLAVES  (NO_SLAVES),
    .DATA_WIDTH (DATA_WIDTH),
    .ACK_TIMEOUT(ACK_TIMEOUT)
  ) DUT (
    .clk       (clk),
    .rstN      (rstN),
    .port_in   (port_in),
    .port_out  (port_out),
    .byte_data (byte_data),
    .byte_valid(byte_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle > cycle_limit) begin
      $display("run stopped, the tests did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // byte collector, one slot list per slave
  always @(negedge clk) begin
    for (int s = 0; s < NO_SLAVES; s++) begin
      if (byte_valid[s] && got_cnt[s] < MAX_BYTES) begin
        got_mem[s][got_cnt[s]] = byte_data[s];
        got_cnt[s]++;
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic int frame_field(input int m, input int f);
    return 1 + 7 * m + f;
  endfunction

  // worst case length of a test in cycles
  function automatic int test_budget(input int t);
    int worst;
    int len;
    worst = 0;
    for (int m = 0; m < NO_MASTERS; m++) begin
      len = gold[t][frame_field(m, F_DLY)] + 3 + S_ID_WIDTH + 2 * ACK_TIMEOUT + 8
            + 2 * (MAX_GAP + 1) * (gold[t][frame_field(m, F_NB)] + 1);
      if (gold[t][frame_field(m, F_EN)] != 0 && len > worst) begin
        worst = len;
      end
    end
    return worst + 8;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp, got);
    $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    errors++;
  endtask

  task automatic drive_bit(input int m, input logic b);
    @(posedge clk);
    #2;
    port_in[m] = b;
  endtask

  task automatic read_golden();
    int          fd;
    int          n;
    string       line;
    logic [31:0] v [NO_FIELDS];
    num_tests = 0;
    fd = $fopen("verif/serial_bus_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/serial_bus_golden.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && num_tests < MAX_TESTS) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                  v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20]);
      if (n != NO_FIELDS) begin
        $display("golden test %0d has %0d fields, %0d needed", num_tests + 1, n, NO_FIELDS);
        errors++;
        continue;
      end
      for (int i = 0; i < NO_FIELDS; i++) begin
        gold[num_tests][i] = v[i];
      end
      num_tests++;
    end
    $fclose(fd);
    if (num_tests == 0) begin
      $display("the golden file holds no tests");
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one master: frame out, response back
  //////////////////////////////////////////////////////////////////////
  task automatic send_frame(input int m, input int t);
    logic [31:0] data;
    logic [2:0]  pat;
    logic [2:0]  exp_rsp;
    logic [1:0]  sym;
    int          nbits;
    int          last_id_cycle;
    int          latency;
    int          exp_latency;
    int          gaps;
    if (gold[t][frame_field(m, F_EN)] == 0) begin
      return;
    end
    data    = gold[t][frame_field(m, F_DATA)];
    nbits   = gold[t][frame_field(m, F_NB)];
    exp_rsp = gold[t][frame_field(m, F_RSP)][2:0];
    repeat (gold[t][frame_field(m, F_DLY)]) @(posedge clk);
    repeat (3) drive_bit(m, 1'b1);
    for (int i = S_ID_WIDTH - 1; i >= 0; i--) begin
      drive_bit(m, gold[t][frame_field(m, F_ID)][i]);
    end
    last_id_cycle = cycle + 1;   // edge that samples the last id bit
    pat = '0;
    while (pat[2] == 1'b0) begin
      drive_bit(m, 1'b0);
      @(negedge clk);
      pat[2] = port_out[m];
    end
    latency = cycle - last_id_cycle;
    for (int i = 1; i >= 0; i--) begin
      drive_bit(m, 1'b0);
      @(negedge clk);
      pat[i] = port_out[m];
    end
    checks++;
    assert (pat == exp_rsp)
      else report_mismatch($sformatf("port_out[%0d] response", m), 32'(exp_rsp), 32'(pat));
    if (gold[t][frame_field(m, F_LAT)] != 0) begin
      exp_latency = (exp_rsp == RSP_ACK) ? 2 : ACK_TIMEOUT + 1;
      checks++;
      assert (latency == exp_latency)
        else report_mismatch($sformatf("port_out[%0d] latency", m), exp_latency, latency);
    end
    if (pat != RSP_ACK) begin
      return;
    end
    for (int i = nbits - 1; i >= 0; i--) begin
      gaps = 0;
      if (gold[t][F_GAP] != 0) begin
        rng_state[m] = xorshift32(rng_state[m]);
        gaps = rng_state[m] % (MAX_GAP + 1);
      end
      repeat (2 * gaps) drive_bit(m, 1'b0);   // idle pairs
      sym = data[i] ? SYM_ONE : SYM_ZERO;
      drive_bit(m, sym[1]);
      drive_bit(m, sym[0]);
    end
    drive_bit(m, SYM_END[1]);
    drive_bit(m, SYM_END[0]);
    drive_bit(m, 1'b0);
  endtask

  task automatic run_test(input int t);
    int    err_start;
    int    base [NO_SLAVES];
    int    cnt;
    byte_t exp_byte;
    err_start = errors;
    for (int s = 0; s < NO_SLAVES; s++) begin
      base[s] = got_cnt[s];
    end
    fork
      send_frame(0, t);
      send_frame(1, t);
    join
    repeat (6) @(posedge clk);   // last byte out, ports back in IDLE
    for (int s = 0; s < NO_SLAVES; s++) begin
      cnt = gold[t][F_SLV + 2 * s];
      checks++;
      assert (got_cnt[s] - base[s] == cnt)
        else report_mismatch($sformatf("byte_valid[%0d] pulses", s), cnt, got_cnt[s] - base[s]);
      for (int i = 0; i < cnt && base[s] + i < got_cnt[s]; i++) begin
        exp_byte = byte_t'(gold[t][F_SLV + 2 * s + 1] >> (DATA_WIDTH * (cnt - 1 - i)));
        checks++;
        assert (got_mem[s][base[s] + i] == exp_byte)
          else report_mismatch($sformatf("byte_data[%0d]", s), 32'(exp_byte),
                               32'(got_mem[s][base[s] + i]));
      end
    end
    if (errors == err_start) begin
      $display("test %0d ok", t + 1);
      passed++;
    end else begin
      $display("test %0d failed with %0d errors", t + 1, errors - err_start);
      failed++;
    end
  endtask

  initial begin
    port_in      = '0;
    rstN         = 1'b0;
    rng_state[0] = SEED;
    rng_state[1] = SEED ^ 32'h9e37_79b9;   // own sequence for master 1
    read_golden();
    cycle_limit = 8;
    for (int t = 0; t < num_tests; t++) begin
      cycle_limit += test_budget(t);
    end
    repeat (2) @(posedge clk);
    #2;
    rstN = 1'b1;
    repeat (2) @(posedge clk);
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             num_tests, passed, failed, checks, errors);
    if (errors == 0 && failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
